/* rtl/vdecode_pkg.sv */
package vdecode_pkg;

  // one register group at SEW 32, LMUL 1
  localparam int MAX_VL   = 32;
  localparam int OFFSET_W = 6;
  localparam int XLEN     = 32;

  // funct6 of the supported OPI operations
  localparam logic [5:0] FUNCT6_VADD       = 6'b000000;
  localparam logic [5:0] FUNCT6_VSUB       = 6'b000010;
  localparam logic [5:0] FUNCT6_VRGATHER   = 6'b001100;
  localparam logic [5:0] FUNCT6_VSLIDEUP   = 6'b001110;
  localparam logic [5:0] FUNCT6_VSLIDEDOWN = 6'b001111;

  // funct3 operand categories
  localparam logic [2:0] FUNCT3_OPIVV = 3'b000;
  localparam logic [2:0] FUNCT3_OPIVI = 3'b011;
  localparam logic [2:0] FUNCT3_OPIVX = 3'b100;

  typedef logic [OFFSET_W-1:0] offset_t;

  typedef enum logic [2:0] {
    VOP_ADD,
    VOP_SUB,
    VOP_SLIDEUP,
    VOP_SLIDEDOWN,
    VOP_RGATHER,
    VOP_ILLEGAL
  } vop_t;

  typedef enum logic [2:0] {
    OPIVV = FUNCT3_OPIVV,
    OPIVI = FUNCT3_OPIVI,
    OPIVX = FUNCT3_OPIVX
  } operand_t;

  typedef enum logic [1:0] {
    VS2_SRC_NORMAL,
    VS2_SRC_IDX_PLUS_RS1,
    VS2_SRC_IDX_PLUS_UIMM,
    VS2_SRC_RS1
  } vs2_src_t;

  typedef enum logic [1:0] {
    VD_SRC_NORMAL,
    VD_SRC_IDX_PLUS_RS1,
    VD_SRC_IDX_PLUS_UIMM
  } vd_src_t;

endpackage

/* rtl/vop_if.sv */
`timescale 1ns/1ps

interface vop_if;
  import vdecode_pkg::*;

  vop_t            op;
  vs2_src_t        vs2_src;
  vd_src_t         vd_src;
  logic [4:0]      vs1;
  logic [4:0]      vs2;
  logic [4:0]      vd;
  logic            masked;
  logic [4:0]      uimm;
  logic [XLEN-1:0] imm;
  logic            legal;

  modport decoder (
    output op, vs2_src, vd_src, vs1, vs2, vd, masked, uimm, imm, legal
  );

  modport consumer (
    input op, vs2_src, vd_src, vs1, vs2, vd, masked, uimm, imm, legal
  );

endinterface

/* rtl/vop_decoder.sv */
`timescale 1ns/1ps

module vop_decoder (
  input logic [31:0] instr,
  vop_if.decoder     dec
);
  import vdecode_pkg::*;

  logic [5:0] funct6;
  logic [4:0] simm5;
  operand_t   cat;
  logic       is_vv;
  logic       is_vx;
  logic       is_vi;

  assign funct6 = instr[31:26];
  assign simm5  = instr[19:15];
  assign cat    = operand_t'(instr[14:12]);
  assign is_vv  = (cat == OPIVV);
  assign is_vx  = (cat == OPIVX);
  assign is_vi  = (cat == OPIVI);

  // register fields sit at fixed positions for all OPI forms
  assign dec.vs2    = instr[24:20];
  assign dec.vs1    = instr[19:15];
  assign dec.vd     = instr[11:7];
  assign dec.uimm   = simm5;
  assign dec.masked = ~instr[25];

  // legality table, kept apart from the op decode below
  assign dec.legal = (funct6 == FUNCT6_VADD && (is_vv || is_vx || is_vi)) ||
                     (funct6 == FUNCT6_VSUB && (is_vv || is_vx)) ||
                     (funct6 == FUNCT6_VSLIDEUP && (is_vx || is_vi)) ||
                     (funct6 == FUNCT6_VSLIDEDOWN && (is_vx || is_vi)) ||
                     (funct6 == FUNCT6_VRGATHER && is_vx);

  always_comb begin
    dec.op = VOP_ILLEGAL;
    case (funct6)
      FUNCT6_VADD:       if (is_vv || is_vx || is_vi) dec.op = VOP_ADD;
      FUNCT6_VSUB:       if (is_vv || is_vx) dec.op = VOP_SUB;
      FUNCT6_VSLIDEUP:   if (is_vx || is_vi) dec.op = VOP_SLIDEUP;
      FUNCT6_VSLIDEDOWN: if (is_vx || is_vi) dec.op = VOP_SLIDEDOWN;
      FUNCT6_VRGATHER:   if (is_vx) dec.op = VOP_RGATHER;
      default:           dec.op = VOP_ILLEGAL;
    endcase
  end

  // offset sources per operation
  always_comb begin
    dec.vs2_src = VS2_SRC_NORMAL;
    dec.vd_src  = VD_SRC_NORMAL;
    case (dec.op)
      VOP_SLIDEDOWN: dec.vs2_src = is_vi ? VS2_SRC_IDX_PLUS_UIMM : VS2_SRC_IDX_PLUS_RS1;
      VOP_SLIDEUP:   dec.vd_src  = is_vi ? VD_SRC_IDX_PLUS_UIMM : VD_SRC_IDX_PLUS_RS1;
      // gather reads one element at xs1
      VOP_RGATHER:   dec.vs2_src = VS2_SRC_RS1;
      default: begin
        dec.vs2_src = VS2_SRC_NORMAL;
        dec.vd_src  = VD_SRC_NORMAL;
      end
    endcase
  end

  // only add.vi sign extends simm5
  assign dec.imm = (dec.op == VOP_ADD && is_vi) ? {{(XLEN-5){simm5[4]}}, simm5} :
                                                  {{(XLEN-5){1'b0}}, simm5};

  // op case and legality table must agree
  always_comb begin
    a_illegal_not_legal: assert (dec.op != VOP_ILLEGAL || !dec.legal)
      else $error("illegal op decoded as legal, instr %h", instr);
  end

endmodule

/* rtl/element_counter.sv */
`timescale 1ns/1ps

module element_counter (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 start,
  input  logic                 advance,
  input  logic                 clear,
  input  vdecode_pkg::offset_t vstart,
  input  vdecode_pkg::offset_t vl,
  output vdecode_pkg::offset_t idx,
  output logic                 active,
  output logic                 last
);
  import vdecode_pkg::*;

  offset_t idx_q;
  logic    active_q;

  assign idx    = idx_q;
  assign active = active_q;

  // pair at idx, idx+1 is the final one
  // vstart >= vl lands here on the first pair as well
  assign last = ({1'b0, idx_q} + 7'd2) >= {1'b0, vl};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      idx_q    <= '0;
      active_q <= 1'b0;
    end else if (clear) begin
      active_q <= 1'b0;
    end else if (start) begin
      idx_q    <= vstart;
      active_q <= 1'b1;
    end else if (advance) begin
      idx_q <= idx_q + offset_t'(2);
      if (last) begin
        active_q <= 1'b0;
      end
    end
  end

  // control only advances a live walk
  a_advance_active: assert property (@(posedge CLK) disable iff (!nRST)
    advance |-> active_q);

  // vl stays within one register group for the whole walk
  a_vl_range: assert property (@(posedge CLK) disable iff (!nRST)
    active_q |-> (vl <= offset_t'(MAX_VL)));

endmodule

/* rtl/lane_addr_gen.sv */
`timescale 1ns/1ps

module lane_addr_gen (
  vop_if.consumer                    dec,
  input  vdecode_pkg::offset_t       idx,
  input  vdecode_pkg::offset_t       vl,
  input  vdecode_pkg::offset_t       vstart,
  input  logic [vdecode_pkg::XLEN-1:0] xs1,
  input  logic                       mask0,
  input  logic                       mask1,
  output vdecode_pkg::offset_t       vs2_offset0,
  output vdecode_pkg::offset_t       vs2_offset1,
  output vdecode_pkg::offset_t       woffset0,
  output vdecode_pkg::offset_t       woffset1,
  output logic                       wen0,
  output logic                       wen1
);
  import vdecode_pkg::*;

  offset_t xs1_off;
  offset_t uimm_off;
  offset_t idx1;
  logic    run_ok;
  logic    lane0_ok;
  logic    lane1_ok;

  // sums wrap modulo 64, so truncating xs1 first is safe
  assign xs1_off  = xs1[OFFSET_W-1:0];
  assign uimm_off = offset_t'(dec.uimm);
  assign idx1     = idx + offset_t'(1);

  always_comb begin
    case (dec.vs2_src)
      VS2_SRC_IDX_PLUS_RS1: begin
        vs2_offset0 = idx + xs1_off;
        vs2_offset1 = idx1 + xs1_off;
      end
      VS2_SRC_IDX_PLUS_UIMM: begin
        vs2_offset0 = idx + uimm_off;
        vs2_offset1 = idx1 + uimm_off;
      end
      VS2_SRC_RS1: begin
        vs2_offset0 = xs1_off;
        vs2_offset1 = xs1_off;
      end
      default: begin
        vs2_offset0 = idx;
        vs2_offset1 = idx1;
      end
    endcase
  end

  always_comb begin
    case (dec.vd_src)
      VD_SRC_IDX_PLUS_RS1: begin
        woffset0 = idx + xs1_off;
        woffset1 = idx1 + xs1_off;
      end
      VD_SRC_IDX_PLUS_UIMM: begin
        woffset0 = idx + uimm_off;
        woffset1 = idx1 + uimm_off;
      end
      default: begin
        woffset0 = idx;
        woffset1 = idx1;
      end
    endcase
  end

  // lane validity compared one bit wider, no wrap
  assign run_ok   = dec.legal && (vstart < vl);
  assign lane0_ok = {1'b0, idx} < {1'b0, vl};
  assign lane1_ok = ({1'b0, idx} + 7'd1) < {1'b0, vl};

  // v0 bit gates only masked forms
  assign wen0 = run_ok && lane0_ok && (!dec.masked || mask0);
  assign wen1 = run_ok && lane1_ok && (!dec.masked || mask1);

endmodule

/* rtl/vdecode_ctrl.sv */
`timescale 1ns/1ps

module vdecode_ctrl (
  input  logic CLK,
  input  logic nRST,
  input  logic v_start,
  input  logic stall,
  input  logic flush,
  input  logic v_done,
  input  logic active,
  input  logic last,
  output logic busy,
  output logic start,
  output logic advance,
  output logic clear,
  output logic load
);

  logic busy_q;

  // held from v_start until execute reports done or a flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy_q <= 1'b0;
    end else if (v_done || flush) begin
      busy_q <= 1'b0;
    end else if (v_start) begin
      busy_q <= 1'b1;
    end
  end

  // busy already shows in the start cycle
  assign busy = busy_q | v_start;

  assign start   = v_start;
  assign advance = active & ~stall;
  assign clear   = flush;
  // every advancing pair goes into the pipeline register
  assign load    = advance;

  a_no_restart: assert property (@(posedge CLK) disable iff (!nRST)
    busy_q |-> !v_start);

  // the counter stops right after the last pair is taken
  a_last_stops: assert property (@(posedge CLK) disable iff (!nRST)
    (advance && last && !v_start) |=> !active);

endmodule

/* rtl/decode_exec_reg.sv */
`timescale 1ns/1ps

module decode_exec_reg (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         load,
  input  logic                         clear,
  input  logic                         last,
  vop_if.consumer                      dec,
  input  vdecode_pkg::offset_t         vs2_offset0,
  input  vdecode_pkg::offset_t         vs2_offset1,
  input  vdecode_pkg::offset_t         woffset0,
  input  vdecode_pkg::offset_t         woffset1,
  input  logic                         wen0,
  input  logic                         wen1,
  output logic                         ex_valid,
  output logic                         ex_last,
  output vdecode_pkg::vop_t            ex_op,
  output logic [4:0]                   ex_vd,
  output logic [4:0]                   ex_vs1,
  output logic [4:0]                   ex_vs2,
  output logic [vdecode_pkg::XLEN-1:0] ex_imm,
  output vdecode_pkg::offset_t         ex_vs2_offset0,
  output vdecode_pkg::offset_t         ex_vs2_offset1,
  output vdecode_pkg::offset_t         ex_woffset0,
  output vdecode_pkg::offset_t         ex_woffset1,
  output logic                         ex_wen0,
  output logic                         ex_wen1
);
  import vdecode_pkg::*;

  // valid, last and enables are single cycle strobes
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_valid <= 1'b0;
      ex_last  <= 1'b0;
      ex_wen0  <= 1'b0;
      ex_wen1  <= 1'b0;
    end else if (clear) begin
      ex_valid <= 1'b0;
      ex_last  <= 1'b0;
      ex_wen0  <= 1'b0;
      ex_wen1  <= 1'b0;
    end else begin
      ex_valid <= load;
      ex_last  <= load & last;
      ex_wen0  <= load & wen0;
      ex_wen1  <= load & wen1;
    end
  end

  // pair payload
  always_ff @(posedge CLK) begin
    if (clear) begin
      ex_op          <= vop_t'(0);
      ex_vd          <= '0;
      ex_vs1         <= '0;
      ex_vs2         <= '0;
      ex_imm         <= '0;
      ex_vs2_offset0 <= '0;
      ex_vs2_offset1 <= '0;
      ex_woffset0    <= '0;
      ex_woffset1    <= '0;
    end else if (load) begin
      ex_op          <= dec.op;
      ex_vd          <= dec.vd;
      ex_vs1         <= dec.vs1;
      ex_vs2         <= dec.vs2;
      ex_imm         <= dec.imm;
      ex_vs2_offset0 <= vs2_offset0;
      ex_vs2_offset1 <= vs2_offset1;
      ex_woffset0    <= woffset0;
      ex_woffset1    <= woffset1;
    end
  end

endmodule

/* rtl/vdecode_stage.sv */
`timescale 1ns/1ps

module vdecode_stage (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         v_start,
  input  logic [31:0]                  instr,
  input  vdecode_pkg::offset_t         vl,
  input  vdecode_pkg::offset_t         vstart,
  input  logic [vdecode_pkg::XLEN-1:0] xs1,
  input  logic                         mask0,
  input  logic                         mask1,
  input  logic                         stall,
  input  logic                         flush,
  input  logic                         v_done,
  output logic                         busy,
  output logic                         ex_valid,
  output logic                         ex_last,
  output vdecode_pkg::vop_t            ex_op,
  output logic [4:0]                   ex_vd,
  output logic [4:0]                   ex_vs1,
  output logic [4:0]                   ex_vs2,
  output logic [vdecode_pkg::XLEN-1:0] ex_imm,
  output vdecode_pkg::offset_t         ex_vs2_offset0,
  output vdecode_pkg::offset_t         ex_vs2_offset1,
  output vdecode_pkg::offset_t         ex_woffset0,
  output vdecode_pkg::offset_t         ex_woffset1,
  output logic                         ex_wen0,
  output logic                         ex_wen1
);
  import vdecode_pkg::*;

  offset_t idx;
  offset_t vs2_offset0;
  offset_t vs2_offset1;
  offset_t woffset0;
  offset_t woffset1;
  logic    active;
  logic    last;
  logic    start;
  logic    advance;
  logic    clear;
  logic    load;
  logic    wen0;
  logic    wen1;

  vop_if dec_if ();

  vop_decoder i_decoder (
    .instr (instr),
    .dec   (dec_if.decoder)
  );

  element_counter i_counter (
    .CLK     (CLK),
    .nRST    (nRST),
    .start   (start),
    .advance (advance),
    .clear   (clear),
    .vstart  (vstart),
    .vl      (vl),
    .idx     (idx),
    .active  (active),
    .last    (last)
  );

  lane_addr_gen i_addr_gen (
    .dec         (dec_if.consumer),
    .idx         (idx),
    .vl          (vl),
    .vstart      (vstart),
    .xs1         (xs1),
    .mask0       (mask0),
    .mask1       (mask1),
    .vs2_offset0 (vs2_offset0),
    .vs2_offset1 (vs2_offset1),
    .woffset0    (woffset0),
    .woffset1    (woffset1),
    .wen0        (wen0),
    .wen1        (wen1)
  );

  vdecode_ctrl i_ctrl (
    .CLK     (CLK),
    .nRST    (nRST),
    .v_start (v_start),
    .stall   (stall),
    .flush   (flush),
    .v_done  (v_done),
    .active  (active),
    .last    (last),
    .busy    (busy),
    .start   (start),
    .advance (advance),
    .clear   (clear),
    .load    (load)
  );

  decode_exec_reg i_de_reg (
    .CLK            (CLK),
    .nRST           (nRST),
    .load           (load),
    .clear          (clear),
    .last           (last),
    .dec            (dec_if.consumer),
    .vs2_offset0    (vs2_offset0),
    .vs2_offset1    (vs2_offset1),
    .woffset0       (woffset0),
    .woffset1       (woffset1),
    .wen0           (wen0),
    .wen1           (wen1),
    .ex_valid       (ex_valid),
    .ex_last        (ex_last),
    .ex_op          (ex_op),
    .ex_vd          (ex_vd),
    .ex_vs1         (ex_vs1),
    .ex_vs2         (ex_vs2),
    .ex_imm         (ex_imm),
    .ex_vs2_offset0 (ex_vs2_offset0),
    .ex_vs2_offset1 (ex_vs2_offset1),
    .ex_woffset0    (ex_woffset0),
    .ex_woffset1    (ex_woffset1),
    .ex_wen0        (ex_wen0),
    .ex_wen1        (ex_wen1)
  );

endmodule

/* include/vdecode_model.svh */
`ifndef VDECODE_MODEL_SVH
`define VDECODE_MODEL_SVH

// include after importing vdecode_pkg
typedef struct {
  vop_t            op;
  vs2_src_t        vs2_src;
  vd_src_t         vd_src;
  logic            masked;
  logic [XLEN-1:0] imm;
} model_dec_t;

function automatic model_dec_t decode_instr(input logic [31:0] instr);
  model_dec_t d;
  logic [5:0] f6;
  logic [2:0] f3;
  logic       vi;
  f6 = instr[31:26];
  f3 = instr[14:12];
  vi = (f3 == FUNCT3_OPIVI);
  d.op = VOP_ILLEGAL;
  if (f6 == FUNCT6_VADD && (f3 == FUNCT3_OPIVV || f3 == FUNCT3_OPIVX || vi))
    d.op = VOP_ADD;
  if (f6 == FUNCT6_VSUB && (f3 == FUNCT3_OPIVV || f3 == FUNCT3_OPIVX))
    d.op = VOP_SUB;
  if (f6 == FUNCT6_VSLIDEUP && (f3 == FUNCT3_OPIVX || vi))
    d.op = VOP_SLIDEUP;
  if (f6 == FUNCT6_VSLIDEDOWN && (f3 == FUNCT3_OPIVX || vi))
    d.op = VOP_SLIDEDOWN;
  if (f6 == FUNCT6_VRGATHER && f3 == FUNCT3_OPIVX)
    d.op = VOP_RGATHER;
  d.vs2_src = VS2_SRC_NORMAL;
  d.vd_src  = VD_SRC_NORMAL;
  if (d.op == VOP_SLIDEDOWN)
    d.vs2_src = vi ? VS2_SRC_IDX_PLUS_UIMM : VS2_SRC_IDX_PLUS_RS1;
  if (d.op == VOP_SLIDEUP)
    d.vd_src = vi ? VD_SRC_IDX_PLUS_UIMM : VD_SRC_IDX_PLUS_RS1;
  if (d.op == VOP_RGATHER)
    d.vs2_src = VS2_SRC_RS1;
  d.masked = ~instr[25];
  d.imm = {{(XLEN-5){1'b0}}, instr[19:15]};
  if (d.op == VOP_ADD && vi)
    d.imm = {{(XLEN-5){instr[19]}}, instr[19:15]};
  return d;
endfunction

// true for the final pair of a walk
function automatic bit is_last_pair(input offset_t idx, input offset_t vl);
  return (int'(idx) + 2) >= int'(vl);
endfunction

// expected offsets and enables of the pair at idx
task automatic expect_pair(input model_dec_t d, input offset_t idx, input offset_t vl,
                           input offset_t vstart, input logic [XLEN-1:0] xs1,
                           input logic m0, input logic m1,
                           output offset_t s0, output offset_t s1,
                           output offset_t w0, output offset_t w1,
                           output logic e0, output logic e1);
  offset_t add_s;
  offset_t add_w;
  bit      run;
  add_s = (d.vs2_src == VS2_SRC_IDX_PLUS_RS1) ? offset_t'(xs1) :
          (d.vs2_src == VS2_SRC_IDX_PLUS_UIMM) ? offset_t'(d.imm[4:0]) : '0;
  add_w = (d.vd_src == VD_SRC_IDX_PLUS_RS1) ? offset_t'(xs1) :
          (d.vd_src == VD_SRC_IDX_PLUS_UIMM) ? offset_t'(d.imm[4:0]) : '0;
  s0 = (d.vs2_src == VS2_SRC_RS1) ? offset_t'(xs1) : offset_t'(idx + add_s);
  s1 = (d.vs2_src == VS2_SRC_RS1) ? offset_t'(xs1) : offset_t'(idx + add_s + 1);
  w0 = offset_t'(idx + add_w);
  w1 = offset_t'(idx + add_w + 1);
  run = (d.op != VOP_ILLEGAL) && (vstart < vl);
  e0 = run && (int'(idx) < int'(vl)) && (!d.masked || m0);
  e1 = run && (int'(idx) + 1 < int'(vl)) && (!d.masked || m1);
endtask

`endif

/* sim/tb_vdecode_stage.sv */
`timescale 1ns/1ps

module tb_vdecode_stage;
  import vdecode_pkg::*;

  `include "vdecode_model.svh"

  localparam int N_INSTR    = 300;
  localparam int WAIT_LIMIT = 100;

  logic            CLK;
  logic            nRST;
  logic            v_start;
  logic [31:0]     instr;
  offset_t         vl;
  offset_t         vstart;
  logic [XLEN-1:0] xs1;
  logic            mask0;
  logic            mask1;
  logic            stall;
  logic            flush;
  logic            v_done;
  logic            busy;
  logic            ex_valid;
  logic            ex_last;
  vop_t            ex_op;
  logic [4:0]      ex_vd;
  logic [4:0]      ex_vs1;
  logic [4:0]      ex_vs2;
  logic [XLEN-1:0] ex_imm;
  offset_t         ex_vs2_offset0;
  offset_t         ex_vs2_offset1;
  offset_t         ex_woffset0;
  offset_t         ex_woffset1;
  logic            ex_wen0;
  logic            ex_wen1;
  integer          seed;

  vdecode_stage i_dut (
    .CLK            (CLK),
    .nRST           (nRST),
    .v_start        (v_start),
    .instr          (instr),
    .vl             (vl),
    .vstart         (vstart),
    .xs1            (xs1),
    .mask0          (mask0),
    .mask1          (mask1),
    .stall          (stall),
    .flush          (flush),
    .v_done         (v_done),
    .busy           (busy),
    .ex_valid       (ex_valid),
    .ex_last        (ex_last),
    .ex_op          (ex_op),
    .ex_vd          (ex_vd),
    .ex_vs1         (ex_vs1),
    .ex_vs2         (ex_vs2),
    .ex_imm         (ex_imm),
    .ex_vs2_offset0 (ex_vs2_offset0),
    .ex_vs2_offset1 (ex_vs2_offset1),
    .ex_woffset0    (ex_woffset0),
    .ex_woffset1    (ex_woffset1),
    .ex_wen0        (ex_wen0),
    .ex_wen1        (ex_wen1)
  );

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  // mostly legal operations, some random codes for the illegal path
  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [5:0]  f6;
    logic [2:0]  f3;
    int          pick;
    r    = $random(seed);
    pick = $unsigned($random(seed)) % 8;
    case (pick)
      0, 1:    f6 = FUNCT6_VADD;
      2:       f6 = FUNCT6_VSUB;
      3:       f6 = FUNCT6_VSLIDEUP;
      4:       f6 = FUNCT6_VSLIDEDOWN;
      5:       f6 = FUNCT6_VRGATHER;
      default: f6 = r[31:26];
    endcase
    pick = $unsigned($random(seed)) % 4;
    case (pick)
      0:       f3 = FUNCT3_OPIVV;
      1:       f3 = FUNCT3_OPIVX;
      2:       f3 = FUNCT3_OPIVI;
      default: f3 = r[14:12];
    endcase
    return {f6, r[25:15], f3, r[11:0]};
  endfunction

  // one random cycle with stall and masks driven at the falling edge
  task automatic drive_cycle();
    logic [31:0] r;
    r     = $random(seed);
    stall = ($unsigned($random(seed)) % 5) == 0;
    mask0 = r[0];
    mask1 = r[1];
  endtask

  // a cycle in which no pair may appear
  task automatic idle_cycle(input logic busy_exp);
    drive_cycle();
    @(posedge CLK);
    #1;
    compare("ex_valid", 64'(ex_valid), 64'(0));
    compare("busy", 64'(busy), 64'(busy_exp));
    @(negedge CLK);
  endtask

  task automatic run_instr();
    model_dec_t d;
    offset_t    idx;
    offset_t    s0;
    offset_t    s1;
    offset_t    w0;
    offset_t    w1;
    logic       e0;
    logic       e1;
    logic       done;
    logic       got;
    int         flush_at;
    int         pairs;
    int         waited;
    v_start = 1'b1;
    stall   = 1'b0;
    instr   = random_instr();
    vl      = offset_t'($unsigned($random(seed)) % (MAX_VL + 1));
    vstart  = offset_t'($unsigned($random(seed)) % (MAX_VL + 1));
    xs1     = $random(seed);
    #1;
    compare("busy", 64'(busy), 64'(1));
    d        = decode_instr(instr);
    idx      = vstart;
    flush_at = ($unsigned($random(seed)) % 8 == 0) ? 1 + $unsigned($random(seed)) % 4 : -1;
    pairs    = 0;
    done     = 1'b0;
    @(negedge CLK);
    v_start = 1'b0;
    compare("ex_valid", 64'(ex_valid), 64'(0));
    while (!done) begin
      if (pairs == flush_at) begin
        // flush in mid walk, nothing more until the next start
        drive_cycle();
        flush = 1'b1;
        @(posedge CLK);
        #1;
        compare("ex_valid", 64'(ex_valid), 64'(0));
        compare("ex_last", 64'(ex_last), 64'(0));
        compare("ex_wen0", 64'(ex_wen0), 64'(0));
        compare("ex_wen1", 64'(ex_wen1), 64'(0));
        compare("busy", 64'(busy), 64'(0));
        @(negedge CLK);
        flush = 1'b0;
        repeat (3) idle_cycle(1'b0);
        return;
      end
      got    = 1'b0;
      waited = 0;
      while (!got) begin
        drive_cycle();
        expect_pair(d, idx, vl, vstart, xs1, mask0, mask1, s0, s1, w0, w1, e0, e1);
        @(posedge CLK);
        #1;
        compare("ex_valid", 64'(ex_valid), 64'(!stall));
        compare("busy", 64'(busy), 64'(1));
        got    = ex_valid;
        waited = waited + 1;
        if (!got && waited > WAIT_LIMIT) begin
          fail_now("timed out waiting for a pair on ex_valid");
        end
        @(negedge CLK);
      end
      compare("ex_last", 64'(ex_last), 64'(is_last_pair(idx, vl)));
      compare("ex_op", 64'(ex_op), 64'(d.op));
      compare("ex_vd", 64'(ex_vd), 64'(instr[11:7]));
      compare("ex_vs1", 64'(ex_vs1), 64'(instr[19:15]));
      compare("ex_vs2", 64'(ex_vs2), 64'(instr[24:20]));
      compare("ex_imm", 64'(ex_imm), 64'(d.imm));
      compare("ex_vs2_offset0", 64'(ex_vs2_offset0), 64'(s0));
      compare("ex_vs2_offset1", 64'(ex_vs2_offset1), 64'(s1));
      compare("ex_woffset0", 64'(ex_woffset0), 64'(w0));
      compare("ex_woffset1", 64'(ex_woffset1), 64'(w1));
      compare("ex_wen0", 64'(ex_wen0), 64'(e0));
      compare("ex_wen1", 64'(ex_wen1), 64'(e1));
      done  = is_last_pair(idx, vl);
      idx   = idx + offset_t'(2);
      pairs = pairs + 1;
    end
    // walk is over, busy holds until done
    repeat ($unsigned($random(seed)) % 3 + 1) idle_cycle(1'b1);
    v_done = 1'b1;
    #1;
    compare("busy", 64'(busy), 64'(1));
    @(posedge CLK);
    #1;
    // latch drops at the edge after done
    compare("busy", 64'(busy), 64'(0));
    @(negedge CLK);
    v_done = 1'b0;
  endtask

  initial begin
    seed    = 32'hdf0cc80f;
    nRST    = 1'b0;
    v_start = 1'b0;
    instr   = '0;
    vl      = '0;
    vstart  = '0;
    xs1     = '0;
    mask0   = 1'b0;
    mask1   = 1'b0;
    stall   = 1'b0;
    flush   = 1'b0;
    v_done  = 1'b0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);
    compare("busy", 64'(busy), 64'(0));
    compare("ex_valid", 64'(ex_valid), 64'(0));
    compare("ex_last", 64'(ex_last), 64'(0));
    compare("ex_wen0", 64'(ex_wen0), 64'(0));
    compare("ex_wen1", 64'(ex_wen1), 64'(0));
    for (int n = 0; n < N_INSTR; n++) begin
      run_instr();
    end
    @(negedge CLK);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* vdecode_stage.f */
+incdir+include
rtl/vdecode_pkg.sv
rtl/vop_if.sv
rtl/vop_decoder.sv
rtl/element_counter.sv
rtl/lane_addr_gen.sv
rtl/vdecode_ctrl.sv
rtl/decode_exec_reg.sv
rtl/vdecode_stage.sv
sim/tb_vdecode_stage.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it, the exit status follows the simulation
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_vdecode_stage \
       -f vdecode_stage.f -o sim_tb_vdecode_stage \
  && ./obj_dir/sim_tb_vdecode_stage \
  || exit 1
